// File: rtl/job_pkg.sv
// job stream layout: word types, miner feed bundle and loader phases
`default_nettype none

package job_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // layout of one job in the word stream
  ////////////////////////////////////////////////////////////////////////////
  localparam int word_w       = 32;
  localparam int target_words = 8;   // also the hash length
  localparam int nonce_words  = 6;   // per miner instance
  localparam int nonce_bytes  = 24;  // chunk length counts the nonce too

  typedef logic [word_w-1:0] word_t;
  typedef word_t [target_words-1:0] target_t;
  typedef word_t [nonce_words-1:0] nonce_t;

  // what the miners see besides target and nonces
  typedef struct packed {
    logic  update;       // new target and nonces valid
    logic  header_wr;    // header_word strobe
    word_t header_word;
  } miner_feed_t;

  typedef enum logic [1:0] {
    ld_idle,
    ld_target,
    ld_nonce,
    ld_header
  } load_phase_e;

endpackage

`default_nettype wire

// File: rtl/result_pkg.sv
// miner report and result record definitions
`default_nettype none

package result_pkg;

  typedef logic [31:0] hash_count_t;

  // one miner instance as seen by the collector
  typedef struct packed {
    logic              found;
    job_pkg::nonce_t   nonce;
    job_pkg::target_t  hash;
    hash_count_t       hash_count;
  } miner_report_t;

  // status word of the record, raw or split
  typedef union packed {
    job_pkg::word_t raw;
    struct packed {
      logic        invalid;  // job ran out of steps
      logic [30:0] count;
    } fields;
  } status_word_u;

  localparam int result_words = 15;  // 6 nonce + status + 8 hash

  typedef enum logic [2:0] {wr_idle, wr_nonce, wr_count, wr_hash, wr_done} writer_state_e;

endpackage

`default_nettype wire

// File: rtl/kernel_control.sv
// kernel control: start edge detection with idle level and done/ready pulse
`default_nettype none

module kernel_control (
  input  wire logic ap_clk_2,
  input  wire logic areset_n_2,
  input  wire logic ap_start,
  input  wire logic result_last,
  output logic      start_pulse,
  output logic      ap_idle,
  output logic      ap_done,
  output logic      ap_ready
);

  logic start_r;

  assign start_pulse = ap_start && !start_r;  // rising edge only
  assign ap_ready    = ap_done;

  always_ff @(posedge ap_clk_2 or negedge areset_n_2) begin
    if (!areset_n_2) begin
      start_r <= 1'b0;
      ap_done <= 1'b0;
      ap_idle <= 1'b1;
    end else begin
      start_r <= ap_start;
      ap_done <= result_last;  // one cycle after the last result word
      if (result_last) begin
        ap_idle <= 1'b1;       // rises together with ap_done
      end else if (start_pulse) begin
        ap_idle <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/job_loader_fsm.sv
// job loader FSM walking the target, nonce and header phases of a job
`default_nettype none

module job_loader_fsm (
  input  wire logic            ap_clk_2,
  input  wire logic            areset_n_2,
  input  wire logic            start_pulse,
  input  wire logic            job_word_valid,
  input  wire logic            last_word,
  output job_pkg::load_phase_e phase,
  output logic                 job_word_take,
  output logic                 accept,
  output logic                 step,
  output logic                 clear
);

  job_pkg::load_phase_e next_phase;
  logic                 phase_end;

  // no word is taken in the restart cycle
  assign job_word_take = (phase != job_pkg::ld_idle) && !start_pulse;
  assign accept        = job_word_valid && job_word_take;
  assign phase_end     = accept && last_word;  // last word of this phase
  assign step          = accept;
  assign clear         = start_pulse || phase_end;

  always_comb begin
    next_phase = phase;
    if (start_pulse) begin
      next_phase = job_pkg::ld_idle;  // abort any load in progress
    end else begin
      case (phase)
        job_pkg::ld_idle: begin
          if (job_word_valid) begin
            next_phase = job_pkg::ld_target;
          end
        end
        job_pkg::ld_target: begin
          if (phase_end) begin
            next_phase = job_pkg::ld_nonce;
          end
        end
        job_pkg::ld_nonce: begin
          if (phase_end) begin
            next_phase = job_pkg::ld_header;
          end
        end
        default: begin
          if (phase_end) begin
            next_phase = job_pkg::ld_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge ap_clk_2 or negedge areset_n_2) begin
    if (!areset_n_2) begin
      phase <= job_pkg::ld_idle;
    end else begin
      phase <= next_phase;
    end
  end

endmodule

`default_nettype wire

// File: rtl/job_word_counter.sv
// word counter within the current load phase, with its last-word flag
`default_nettype none

module job_word_counter #(
  parameter int inst_num = 2
) (
  input  wire logic                 ap_clk_2,
  input  wire logic                 areset_n_2,
  input  wire job_pkg::load_phase_e phase,
  input  wire logic                 step,
  input  wire logic                 clear,
  input  wire logic [15:0]          chunk_length,
  output logic [7:0]                index,
  output logic                      last_word
);

  logic [16:0] header_bytes_up;  // header bytes plus 3 for rounding up
  logic [7:0]  header_cnt;
  logic [7:0]  limit;

  assign header_bytes_up = {1'b0, chunk_length} - 17'(job_pkg::nonce_bytes) + 17'd3;

  always_ff @(posedge ap_clk_2 or negedge areset_n_2) begin
    if (!areset_n_2) begin
      header_cnt <= '0;
      index      <= '0;
    end else begin
      header_cnt <= header_bytes_up[9:2];  // whole words, header stays below 256
      if (clear) begin
        index <= '0;
      end else if (step) begin
        index <= index + 8'd1;
      end
    end
  end

  // words in the current phase
  always_comb begin
    case (phase)
      job_pkg::ld_target: limit = 8'(job_pkg::target_words);
      job_pkg::ld_nonce:  limit = 8'(job_pkg::nonce_words * inst_num);
      job_pkg::ld_header: limit = header_cnt;
      default:            limit = '0;
    endcase
  end

  assign last_word = (limit != '0) && (index == limit - 8'd1);

endmodule

`default_nettype wire

// File: rtl/job_register_file.sv
// target and nonce storage, update strobe and header forwarding to the miners
`default_nettype none

module job_register_file #(
  parameter int inst_num = 2
) (
  input  wire logic                      ap_clk_2,
  input  wire logic                      areset_n_2,
  input  wire job_pkg::load_phase_e      phase,
  input  wire logic [7:0]                index,
  input  wire logic                      accept,
  input  wire job_pkg::word_t            job_word,
  input  wire logic                      last_word,
  output job_pkg::target_t               target,
  output job_pkg::nonce_t [inst_num-1:0] nonces,
  output job_pkg::miner_feed_t           miner_feed
);

  logic           take_target, take_nonce, take_header;
  logic           update_r, header_wr_r;
  job_pkg::word_t header_word_r;

  assign take_target = accept && (phase == job_pkg::ld_target);
  assign take_nonce  = accept && (phase == job_pkg::ld_nonce);
  assign take_header = accept && (phase == job_pkg::ld_header);

  // first word of each block lands in its top word, instance 0 first
  always_ff @(posedge ap_clk_2) begin
    for (int w = 0; w < job_pkg::target_words; w++) begin
      if (take_target && index == 8'(job_pkg::target_words - 1 - w)) begin
        target[w] <= job_word;
      end
    end
    for (int i = 0; i < inst_num; i++) begin
      for (int w = 0; w < job_pkg::nonce_words; w++) begin
        if (take_nonce && index == 8'(i * job_pkg::nonce_words + job_pkg::nonce_words - 1 - w)) begin
          nonces[i][w] <= job_word;
        end
      end
    end
    if (take_header) begin
      header_word_r <= job_word;
    end
  end

  always_ff @(posedge ap_clk_2 or negedge areset_n_2) begin
    if (!areset_n_2) begin
      update_r    <= 1'b0;
      header_wr_r <= 1'b0;
    end else begin
      update_r    <= take_nonce && last_word;  // after the final nonce word
      header_wr_r <= take_header;
    end
  end

  assign miner_feed = '{update: update_r, header_wr: header_wr_r, header_word: header_word_r};

endmodule

`default_nettype wire

// File: rtl/winner_collector.sv
// winner capture, hash count accumulation and invalid job detection
`default_nettype none

module winner_collector #(
  parameter int inst_num = 2
) (
  input  wire logic                                    ap_clk_2,
  input  wire logic                                    areset_n_2,
  input  wire result_pkg::miner_report_t [inst_num-1:0] miner_reports,
  input  wire logic [31:0]                             mining_steps,
  input  wire logic                                    update,
  input  wire logic                                    writer_idle,
  output logic                                         trigger,
  output job_pkg::nonce_t                              winner_nonce,
  output job_pkg::target_t                             winner_hash,
  output result_pkg::hash_count_t                      acc_count,
  output logic                                         invalid
);

  logic                    any_found, found_r;
  logic                    invalid_now, invalid_pulse;
  job_pkg::nonce_t         sel_nonce;
  job_pkg::target_t        sel_hash;
  result_pkg::hash_count_t count_sum;

  // walk downwards so the lowest found index wins
  always_comb begin
    any_found = 1'b0;
    sel_nonce = '0;
    sel_hash  = '0;
    count_sum = '0;
    for (int i = inst_num - 1; i >= 0; i--) begin
      if (miner_reports[i].found) begin
        any_found = 1'b1;
        sel_nonce = miner_reports[i].nonce;
        sel_hash  = miner_reports[i].hash;
      end
      count_sum = count_sum + miner_reports[i].hash_count;
    end
  end

  // instance 0 ran all its steps without a hit
  assign invalid_now   = (miner_reports[0].hash_count == mining_steps) && !found_r;
  assign invalid_pulse = invalid_now && !invalid;
  assign trigger       = found_r || invalid_pulse;

  always_ff @(posedge ap_clk_2) begin
    if (any_found && writer_idle) begin
      winner_nonce <= sel_nonce;
      winner_hash  <= sel_hash;
    end
  end

  always_ff @(posedge ap_clk_2 or negedge areset_n_2) begin
    if (!areset_n_2) begin
      found_r   <= 1'b0;
      invalid   <= 1'b1;  // disarmed until the first job arrives
      acc_count <= '0;
    end else begin
      found_r <= any_found;
      if (update) begin
        invalid <= 1'b0;
      end else if (invalid_now) begin
        invalid <= 1'b1;
      end
      if (update) begin
        acc_count <= '0;
      end else if ((any_found || invalid_pulse) && writer_idle) begin
        acc_count <= count_sum;  // snapshot of all instances
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/result_writer_fsm.sv
// result writer FSM sending the 15-word record of nonce, status and hash
`default_nettype none

module result_writer_fsm (
  input  wire logic                    ap_clk_2,
  input  wire logic                    areset_n_2,
  input  wire logic                    start_pulse,
  input  wire logic                    update,
  input  wire logic                    trigger,
  input  wire job_pkg::nonce_t         winner_nonce,
  input  wire job_pkg::target_t        winner_hash,
  input  wire result_pkg::hash_count_t acc_count,
  input  wire logic                    invalid,
  output logic                         writer_idle,
  output job_pkg::word_t               result_word,
  output logic                         result_valid,
  output logic                         result_last
);

  result_pkg::writer_state_e st, next_st;
  logic [3:0]                idx;       // word number within the record
  logic [3:0]                nonce_pos;
  logic [3:0]                hash_pos;
  result_pkg::status_word_u  status;

  assign nonce_pos = 4'(job_pkg::nonce_words - 1) - idx;  // msw first
  assign hash_pos  = 4'(result_pkg::result_words - 1) - idx;

  assign writer_idle  = (st == result_pkg::wr_idle);
  assign result_valid = (st == result_pkg::wr_nonce) || (st == result_pkg::wr_count) ||
                        (st == result_pkg::wr_hash);
  assign result_last  = (st == result_pkg::wr_hash) &&
                        (idx == 4'(result_pkg::result_words - 1));

  always_comb begin
    status.fields.invalid = invalid;
    status.fields.count   = acc_count[30:0];
    case (st)
      result_pkg::wr_nonce: result_word = winner_nonce[nonce_pos[2:0]];
      result_pkg::wr_count: result_word = status.raw;
      result_pkg::wr_hash:  result_word = winner_hash[hash_pos[2:0]];
      default:              result_word = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    next_st = st;
    case (st)
      result_pkg::wr_idle: begin
        if (trigger) begin
          next_st = result_pkg::wr_nonce;
        end
      end
      result_pkg::wr_nonce: begin
        if (idx == 4'(job_pkg::nonce_words - 1)) begin
          next_st = result_pkg::wr_count;
        end
      end
      result_pkg::wr_count: next_st = result_pkg::wr_hash;
      result_pkg::wr_hash: begin
        if (result_last) begin
          next_st = result_pkg::wr_done;
        end
      end
      default: begin
        if (update) begin
          next_st = result_pkg::wr_idle;  // wait for the next job
        end
      end
    endcase
    if (start_pulse) begin
      next_st = result_pkg::wr_idle;
    end
  end

  always_ff @(posedge ap_clk_2 or negedge areset_n_2) begin
    if (!areset_n_2) begin
      st  <= result_pkg::wr_idle;
      idx <= '0;
    end else begin
      st  <= next_st;
      idx <= result_valid && !result_last ? idx + 4'd1 : 4'd0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/alephminer_core.sv
// mining kernel core: job loading, winner collection and result record output
`default_nettype none

module alephminer_core #(
  parameter int inst_num = 2
) (
  input  wire logic                                    ap_clk_2,
  input  wire logic                                    areset_n_2,
  input  wire logic                                    ap_start,
  input  wire job_pkg::word_t                          job_word,
  input  wire logic                                    job_word_valid,
  input  wire logic [15:0]                             chunk_length,
  input  wire logic [31:0]                             mining_steps,
  input  wire result_pkg::miner_report_t [inst_num-1:0] miner_reports,
  output logic                                         job_word_take,
  output job_pkg::miner_feed_t                         miner_feed,
  output job_pkg::target_t                             target,
  output job_pkg::nonce_t [inst_num-1:0]               nonces,
  output job_pkg::word_t                               result_word,
  output logic                                         result_valid,
  output logic                                         result_last,
  output logic                                         ap_idle,
  output logic                                         ap_done,
  output logic                                         ap_ready
);

  logic                    start_pulse;
  job_pkg::load_phase_e    phase;
  logic                    accept, step, clear, last_word;
  logic [7:0]              index;
  logic                    writer_idle, trigger, invalid;
  job_pkg::nonce_t         winner_nonce;
  job_pkg::target_t        winner_hash;
  result_pkg::hash_count_t acc_count;

  kernel_control u_ctrl (
    .ap_clk_2, .areset_n_2, .ap_start, .result_last,
    .start_pulse, .ap_idle, .ap_done, .ap_ready
  );

  ////////////////////////////////////////////////////////////////////////////
  // job side
  ////////////////////////////////////////////////////////////////////////////
  job_loader_fsm u_loader (
    .ap_clk_2, .areset_n_2, .start_pulse, .job_word_valid, .last_word,
    .phase, .job_word_take, .accept, .step, .clear
  );

  job_word_counter #(.inst_num(inst_num)) u_counter (
    .ap_clk_2, .areset_n_2, .phase, .step, .clear, .chunk_length,
    .index, .last_word
  );

  job_register_file #(.inst_num(inst_num)) u_regs (
    .ap_clk_2, .areset_n_2, .phase, .index, .accept, .job_word, .last_word,
    .target, .nonces, .miner_feed
  );

  ////////////////////////////////////////////////////////////////////////////
  // result side
  ////////////////////////////////////////////////////////////////////////////
  winner_collector #(.inst_num(inst_num)) u_collect (
    .ap_clk_2, .areset_n_2, .miner_reports, .mining_steps,
    .update(miner_feed.update), .writer_idle,
    .trigger, .winner_nonce, .winner_hash, .acc_count, .invalid
  );

  result_writer_fsm u_writer (
    .ap_clk_2, .areset_n_2, .start_pulse, .update(miner_feed.update),
    .trigger, .winner_nonce, .winner_hash, .acc_count, .invalid,
    .writer_idle, .result_word, .result_valid, .result_last
  );

endmodule

`default_nettype wire

// File: testbench/alephminer_assertions.sv
// protocol assertions on the core's strobes bound into alephminer_core
`default_nettype none

module alephminer_assertions (
  input wire logic ap_clk_2,
  input wire logic areset_n_2,
  input wire logic ap_done,
  input wire logic update,
  input wire logic result_valid,
  input wire logic result_last
);

  int fail_cnt = 0;  // failed assertions so far

  ////////////////////////////////////////////////////////////////////////////
  // single-cycle strobes
  ////////////////////////////////////////////////////////////////////////////
  done_one_cycle: assert property (@(posedge ap_clk_2) disable iff (!areset_n_2)
    ap_done |=> !ap_done)
  else begin
    $error("ap_done held for more than one cycle");
    fail_cnt++;
  end

  update_one_cycle: assert property (@(posedge ap_clk_2) disable iff (!areset_n_2)
    update |=> !update)
  else begin
    $error("miner_feed.update held for more than one cycle");
    fail_cnt++;
  end

  // record ends cleanly
  valid_drops_after_last: assert property (@(posedge ap_clk_2) disable iff (!areset_n_2)
    result_last |=> !result_valid)
  else begin
    $error("result_valid high right after result_last");
    fail_cnt++;
  end

endmodule

bind alephminer_core alephminer_assertions u_assertions (
  .ap_clk_2, .areset_n_2, .ap_done, .update(miner_feed.update),
  .result_valid, .result_last
);

`default_nettype wire

// File: testbench/tb_alephminer.sv
// testbench for the mining kernel core with a job table, miner model and record checks
`default_nettype none

module tb_alephminer;

  typedef struct packed {
    logic [15:0] chunk_length;
    logic [31:0] steps;
    logic [1:0]  found;   // bit i set when instance i reports found
    logic [31:0] cnt0;
    logic [31:0] cnt1;
    logic        abort;   // restart the kernel in the middle of the target
  } job_row_t;

  logic                                    ap_clk_2, areset_n_2, ap_start;
  job_pkg::word_t                          job_word;
  logic                                    job_word_valid;
  logic [15:0]                             chunk_length;
  logic [31:0]                             mining_steps;
  result_pkg::miner_report_t [1:0]         reports;
  logic                                    job_word_take;
  job_pkg::miner_feed_t                    miner_feed;
  job_pkg::target_t                        target;
  job_pkg::nonce_t [1:0]                   nonces;
  job_pkg::word_t                          result_word;
  logic                                    result_valid, result_last;
  logic                                    ap_idle, ap_done, ap_ready;

  job_row_t       jobs [4];
  logic [31:0]    lfsr_state = 32'h1967_6dba;
  int             errors = 0;
  int             passed = 0;
  int             failed = 0;
  int             cycles = 0;
  int             limit = 1000000;
  int             update_cnt, done_cnt, ready_cnt;
  job_pkg::word_t hdr_q[$];
  job_pkg::word_t res_q[$];
  logic           last_q[$];

  alephminer_core #(.inst_num(2)) UUT (
    .ap_clk_2, .areset_n_2, .ap_start, .job_word, .job_word_valid, .chunk_length,
    .mining_steps, .miner_reports(reports), .job_word_take, .miner_feed, .target,
    .nonces, .result_word, .result_valid, .result_last, .ap_idle, .ap_done, .ap_ready
  );

  initial begin
    ap_clk_2 = 1'b0;
    forever #5 ap_clk_2 = ~ap_clk_2;
  end

  // run limit
  always @(posedge ap_clk_2) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout: the DUT stopped responding after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // monitor samples on the falling edge away from the input changes
  always @(negedge ap_clk_2) begin
    if (miner_feed.update) update_cnt++;
    if (miner_feed.header_wr) hdr_q.push_back(miner_feed.header_word);
    if (result_valid) begin
      res_q.push_back(result_word);
      last_q.push_back(result_last);
    end
    if (ap_done) done_cnt++;
    if (ap_ready) ready_cnt++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) s = s ^ 32'hA300_0000;
    return s;
  endfunction

  task automatic rand_word(output job_pkg::word_t w);
    job_pkg::word_t t;
    t = '0;
    for (int b = 0; b < 32; b++) begin
      t = {lfsr_state[0], t[31:1]};  // one step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
    w = t;
  endtask

  task automatic send_word(input job_pkg::word_t w);
    job_word       = w;
    job_word_valid = 1'b1;
    @(negedge ap_clk_2);
    while (!job_word_take) @(negedge ap_clk_2);
    @(posedge ap_clk_2);
    #1;
  endtask

  task automatic pulse_start(input logic check_take);
    @(posedge ap_clk_2);
    #1 ap_start = 1'b1;
    @(negedge ap_clk_2);
    if (check_take) begin
      assert (!job_word_take) else begin
        $display("job_word_take stayed high during a restart");
        errors++;
      end
    end
    @(posedge ap_clk_2);
    #1 ap_start = 1'b0;
    job_word_valid = 1'b0;
    @(negedge ap_clk_2);
    assert (!ap_idle) else begin
      $display("[FAIL] ap_idle exp 0x0 got 0x%h", ap_idle);
      errors++;
    end
  endtask

  task automatic run_row(input job_row_t row);
    job_pkg::word_t words[$];
    job_pkg::word_t w, exp;
    job_pkg::nonce_t  win_nonce [2];
    job_pkg::target_t win_hash [2];
    int hdr, win;
    logic [31:0] sum;
    words.delete();
    hdr_q.delete();
    res_q.delete();
    last_q.delete();
    update_cnt = 0;
    done_cnt = 0;
    ready_cnt = 0;
    hdr = (int'(row.chunk_length) - 24 + 3) / 4;
    chunk_length = row.chunk_length;
    mining_steps = row.steps;
    pulse_start(1'b0);
    if (row.abort) begin
      for (int k = 0; k < 5; k++) begin
        rand_word(w);
        send_word(w);
      end
      pulse_start(1'b1);  // valid still high from the partial load
    end
    for (int k = 0; k < 20 + hdr; k++) begin
      rand_word(w);
      words.push_back(w);
      send_word(w);
    end
    job_word_valid = 1'b0;
    repeat (2) @(negedge ap_clk_2);
    for (int k = 0; k < 8; k++) begin
      assert (target[7 - k] == words[k]) else begin
        $display("[FAIL] target[%0d] exp 0x%h got 0x%h", 7 - k, words[k], target[7 - k]);
        errors++;
      end
    end
    for (int k = 0; k < 12; k++) begin
      assert (nonces[k / 6][5 - k % 6] == words[8 + k]) else begin
        $display("[FAIL] nonces[%0d][%0d] exp 0x%h got 0x%h", k / 6, 5 - k % 6,
                 words[8 + k], nonces[k / 6][5 - k % 6]);
        errors++;
      end
    end
    assert (update_cnt == 1) else begin
      $display("[FAIL] update pulses exp 0x1 got 0x%h", update_cnt);
      errors++;
    end
    assert (hdr_q.size() == hdr) else begin
      $display("[FAIL] header_wr count exp 0x%h got 0x%h", hdr, hdr_q.size());
      errors++;
    end
    for (int k = 0; k < hdr && k < hdr_q.size(); k++) begin
      assert (hdr_q[k] == words[20 + k]) else begin
        $display("[FAIL] header_word exp 0x%h got 0x%h", words[20 + k], hdr_q[k]);
        errors++;
      end
    end

    // miner model answers the new job
    @(posedge ap_clk_2);
    #1;
    for (int i = 0; i < 2; i++) begin
      for (int k = 0; k < 6; k++) rand_word(win_nonce[i][5 - k]);
      for (int k = 0; k < 8; k++) rand_word(win_hash[i][7 - k]);
      reports[i].found = row.found[i];
      reports[i].nonce = win_nonce[i];
      reports[i].hash  = win_hash[i];
    end
    reports[0].hash_count = row.cnt0;
    reports[1].hash_count = row.cnt1;
    win = row.found[0] ? 0 : 1;
    sum = row.cnt0 + row.cnt1;
    while (res_q.size() < 15) @(negedge ap_clk_2);
    for (int k = 0; k < 15; k++) begin
      if (k < 6) exp = win_nonce[win][5 - k];
      else if (k == 6) exp = {row.found == 2'b00, sum[30:0]};
      else exp = win_hash[win][14 - k];
      if (row.found != 2'b00 || k == 6) begin
        assert (res_q[k] == exp) else begin
          $display("[FAIL] result_word %0d exp 0x%h got 0x%h", k, exp, res_q[k]);
          errors++;
        end
      end
      assert (last_q[k] == (k == 14)) else begin
        $display("[FAIL] result_last at word %0d exp 0x%h got 0x%h", k, k == 14, last_q[k]);
        errors++;
      end
    end
    while (done_cnt == 0) @(negedge ap_clk_2);
    @(negedge ap_clk_2);
    assert (done_cnt == 1 && ap_idle) else begin
      $display("[FAIL] ap_done count exp 0x1 got 0x%h, ap_idle 0x%h", done_cnt, ap_idle);
      errors++;
    end
    assert (ready_cnt == 1) else begin
      $display("[FAIL] ap_ready pulses exp 0x1 got 0x%h", ready_cnt);
      errors++;
    end
    @(posedge ap_clk_2);
    #1 reports = '0;  // miners go quiet before the next job
  endtask

  initial begin
    int err_before;
    int max_hdr;
    int row_hdr;
    areset_n_2 = 1'b0;
    ap_start = 1'b0;
    job_word = '0;
    job_word_valid = 1'b0;
    chunk_length = '0;
    mining_steps = 32'd1;
    reports = '0;
    jobs[0] = '{16'd40, 32'd1000, 2'b01, 32'd100, 32'd200, 1'b0};
    jobs[1] = '{16'd61, 32'd500, 2'b10, 32'd300, 32'd77, 1'b0};
    jobs[2] = '{16'd33, 32'd900, 2'b11, 32'h8000_0010, 32'd5, 1'b1};
    jobs[3] = '{16'd25, 32'd64, 2'b00, 32'd64, 32'd9, 1'b1};
    max_hdr = 0;
    foreach (jobs[r]) begin
      row_hdr = (int'(jobs[r].chunk_length) - 24 + 3) / 4;
      if (row_hdr > max_hdr) max_hdr = row_hdr;
    end
    limit = 4 * (20 + max_hdr + 15 + 40);
    repeat (2) @(posedge ap_clk_2);
    #1 areset_n_2 = 1'b1;
    @(negedge ap_clk_2);
    assert (ap_idle && !ap_done && !ap_ready && !result_valid && !job_word_take &&
            !miner_feed.update)
    else begin
      $display("outputs not at their reset values after reset");
      errors++;
    end
    $display("test reset: %s", errors == 0 ? "ok" : "failed");
    foreach (jobs[r]) begin
      err_before = errors;
      run_row(jobs[r]);
      if (errors == err_before) passed++;
      else failed++;
      $display("test job %0d: %s", r, errors == err_before ? "ok" : "failed");
    end
    $display("jobs passed %0d, failed %0d, check errors %0d, assertion failures %0d",
             passed, failed, errors, UUT.u_assertions.fail_cnt);
    if (errors == 0 && UUT.u_assertions.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
rtl/job_pkg.sv
rtl/result_pkg.sv
rtl/kernel_control.sv
rtl/job_loader_fsm.sv
rtl/job_word_counter.sv
rtl/job_register_file.sv
rtl/winner_collector.sv
rtl/result_writer_fsm.sv
rtl/alephminer_core.sv
testbench/alephminer_assertions.sv
testbench/tb_alephminer.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator, then look for the pass line
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_alephminer -f build.f

./obj_dir/Vtb_alephminer > sim.log 2>&1 || true
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
  exit 0
fi
exit 1
